// File: list.f
+incdir+logic
logic/rename_types_pkg.sv
logic/rob_types_pkg.sv
logic/rename_map_table.sv
logic/rename_free_list.sv
logic/rename_stage.sv
logic/reorder_buffer.sv
logic/rename_unit_top.sv
sim/rename_unit_assertions.sv
sim/rename_unit_tb.sv

// File: Makefile
SIM := obj_dir/Vrename_unit_tb
SRCS := $(shell grep -v '^+' list.f) logic/rename_consts.svh

.PHONY: all run clean

all: run

$(SIM): list.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module rename_unit_tb \
		-f list.f -o Vrename_unit_tb

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

// File: sim/rename_unit_tb.sv
`timescale 1ns/1ps
`include "rename_consts.svh"

module rename_unit_tb
  import rename_types_pkg::*, rob_types_pkg::*;
();

  typedef enum logic [1:0] {
    kind_issue,
    kind_complete,
    kind_clear,
    kind_stall
  } step_kind_t;

  typedef struct packed {
    step_kind_t     kind;
    decoded_instr_t instr;
    sb_idx_t        sb;
    rob_idx_t       rob;
    logic           mispredict;
    logic [3:0]     cycles;
  } step_t;

  localparam opcode_t alu_add_op = 4'h0;

  logic           clk_i;
  logic           reset_i;
  decoded_instr_t decoded_i;
  logic           decoded_v_i;
  logic           decode_ready_o;
  renamed_instr_t renamed_o;
  logic           renamed_v_o;
  logic           issue_ready_i;
  logic           complete_v_i;
  complete_rec_t  complete_i;
  sb_idx_t        sb_num_i;
  logic           sb_alloc_v_o;
  logic           sb_clear_v_i;
  sb_idx_t        sb_clear_idx_i;

  integer seed = 32'h1f11_c0f5;
  step_t steps[$];
  logic table_ready = 1'b0;

  // reference model state
  phys_reg_t spec_map [`RN_ARCH_REGS];
  phys_reg_t comm_map [`RN_ARCH_REGS];
  phys_reg_t spec_free[$];
  phys_reg_t comm_free[$];
  rob_entry_t rob_q[$];
  rob_idx_t rob_head;
  rob_idx_t rob_tail;
  sb_idx_t last_sb;
  logic store_pending;
  renamed_instr_t last_out;
  logic last_valid;

  rename_unit_top rename_unit_top_i (
    .clk_i,
    .reset_i,
    .decoded_i,
    .decoded_v_i,
    .decode_ready_o,
    .renamed_o,
    .renamed_v_o,
    .issue_ready_i,
    .complete_v_i,
    .complete_i,
    .sb_num_i,
    .sb_alloc_v_o,
    .sb_clear_v_i,
    .sb_clear_idx_i
  );

  initial
  begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic report_failure();
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped on the first failure");
  endtask

  task automatic check_renamed(input renamed_instr_t got, input renamed_instr_t exp);
    if (got !== exp)
    begin
      $display("ERR %0t: renamed_o %h, expected %h", $time, got, exp);
      report_failure();
    end
  endtask

  task automatic check_ready(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("ERR %0t: %s is %b, expected %b", $time, name, got, exp);
      report_failure();
    end
  endtask

  function automatic word_t random_imm();
    return word_t'($random(seed));
  endfunction

  function automatic decoded_instr_t build_instr(opcode_t op, func_unit_t fu, logic imm,
                                                 logic w, arch_reg_t s1, word_t s2,
                                                 arch_reg_t d);
    decoded_instr_t i;
    i.pc = 32'h1000 + 32'(steps.size()) * 4;
    i.opcode = op;
    i.func_unit = fu;
    i.imm = imm;
    i.w_v = w;
    i.source_1 = s1;
    i.source2_imm = s2;
    i.dest_id = d;
    return i;
  endfunction

  function automatic step_t issue_step(decoded_instr_t instr, sb_idx_t sb);
    step_t s;
    s = '0;
    s.kind = kind_issue;
    s.instr = instr;
    s.sb = sb;
    return s;
  endfunction

  function automatic step_t stall_step(decoded_instr_t instr, logic [3:0] cycles);
    step_t s;
    s = '0;
    s.kind = kind_stall;
    s.instr = instr;
    s.cycles = cycles;
    return s;
  endfunction

  function automatic step_t complete_step(rob_idx_t rob, logic mispredict);
    step_t s;
    s = '0;
    s.kind = kind_complete;
    s.rob = rob;
    s.mispredict = mispredict;
    return s;
  endfunction

  function automatic step_t clear_step(sb_idx_t sb);
    step_t s;
    s = '0;
    s.kind = kind_clear;
    s.sb = sb;
    return s;
  endfunction

  task automatic build_table();
    // writers after reset, then readers of the new mappings
    steps.push_back(issue_step(build_instr(alu_add_op, `RN_FU_ALU, 1'b0, 1'b1, 4'd2, 32'd3,
                                           4'd1), 2'd0));
    steps.push_back(issue_step(build_instr(alu_add_op, `RN_FU_ALU, 1'b1, 1'b1, 4'd1,
                                           random_imm(), 4'd4), 2'd0));
    steps.push_back(stall_step(build_instr(alu_add_op, `RN_FU_ALU, 1'b0, 1'b1, 4'd1, 32'd4,
                                           4'd5), 4'd3));
    // store, load behind it, clear, second load
    steps.push_back(issue_step(build_instr(`RN_OP_STR, `RN_FU_MEM, 1'b0, 1'b0, 4'd5, 32'd1,
                                           4'd0), 2'd2));
    steps.push_back(issue_step(build_instr(`RN_OP_LDR, `RN_FU_MEM, 1'b1, 1'b1, 4'd5, 32'd8,
                                           4'd6), 2'd0));
    steps.push_back(clear_step(2'd2));
    steps.push_back(issue_step(build_instr(`RN_OP_LDR, `RN_FU_MEM, 1'b1, 1'b1, 4'd6, 32'd4,
                                           4'd7), 2'd0));
    // last one finds the reorder buffer full
    for (int r = 8; r <= 10; r++)
      steps.push_back(issue_step(build_instr(alu_add_op, `RN_FU_ALU, 1'b0, 1'b1,
                                             arch_reg_t'(r - 1), 32'd6, arch_reg_t'(r)), 2'd0));
    // out of order completion, in order retirement
    steps.push_back(complete_step(3'd1, 1'b0));
    for (int k = 0; k < `RN_ROB_ENTRIES; k++)
      if (k != 1)
        steps.push_back(complete_step(rob_idx_t'(k), 1'b0));
    // branch with two younger writers, then a mispredict
    steps.push_back(issue_step(build_instr(`RN_OP_BCC, `RN_FU_BRANCH, 1'b1, 1'b0, 4'd1,
                                           random_imm(), 4'd0), 2'd0));
    steps.push_back(issue_step(build_instr(alu_add_op, `RN_FU_ALU, 1'b0, 1'b1, 4'd2, 32'd3,
                                           4'd1), 2'd0));
    steps.push_back(issue_step(build_instr(alu_add_op, `RN_FU_ALU, 1'b1, 1'b1, 4'd1,
                                           random_imm(), 4'd2), 2'd0));
    steps.push_back(complete_step(3'd1, 1'b0));
    steps.push_back(complete_step(3'd0, 1'b1));
    // renamed from committed state
    for (int r = 3; r <= 11; r += 4)
      steps.push_back(issue_step(build_instr(alu_add_op, `RN_FU_ALU, 1'b0, 1'b1, 4'd1, 32'd2,
                                             arch_reg_t'(r == 3 ? 3 : r - 1)), 2'd0));
    for (int k = 0; k < 3; k++)
      steps.push_back(complete_step(rob_idx_t'(k), 1'b0));
    // long enough to reach registers freed at retirement
    for (int r = 12; r < 20; r++)
      steps.push_back(issue_step(build_instr(alu_add_op, `RN_FU_ALU, 1'b0, 1'b1,
                                             arch_reg_t'(r - 1), 32'd3, arch_reg_t'(r)), 2'd0));
  endtask

  task automatic model_reset();
    spec_free.delete();
    comm_free.delete();
    rob_q.delete();
    for (int r = 0; r < `RN_ARCH_REGS; r++)
    begin
      spec_map[r] = phys_reg_t'(r);
      comm_map[r] = phys_reg_t'(r);
    end
    for (int p = `RN_ARCH_REGS; p < `RN_PHYS_REGS; p++)
    begin
      spec_free.push_back(phys_reg_t'(p));
      comm_free.push_back(phys_reg_t'(p));
    end
    rob_head = '0;
    rob_tail = '0;
    last_sb = '0;
    store_pending = 1'b0;
    last_valid = 1'b0;
  endtask

  // expected output for an accepted instruction
  task automatic predict_accept(input decoded_instr_t d, input sb_idx_t sb,
                                output renamed_instr_t r);
    rob_entry_t e;
    logic load;
    logic store;
    load = (d.func_unit == `RN_FU_MEM) && (d.opcode == `RN_OP_LDR);
    store = (d.func_unit == `RN_FU_MEM) && (d.opcode == `RN_OP_STR);
    e = '0;
    e.pc = d.pc;
    e.w_v = d.w_v;
    e.alloc_reg = d.dest_id;
    e.freed_reg = spec_map[d.dest_id];
    e.is_spec = (d.func_unit == `RN_FU_BRANCH) &&
                (d.opcode == `RN_OP_BX || d.opcode == `RN_OP_BCC);
    e.is_store = store;
    r.pc = d.pc;
    r.opcode = d.opcode;
    r.func_unit = d.func_unit;
    r.imm = d.imm;
    r.w_v = d.w_v;
    r.source_1 = spec_map[d.source_1];
    r.source2_imm = d.imm ? d.source2_imm : word_t'(spec_map[arch_reg_t'(d.source2_imm)]);
    if (d.w_v)
    begin
      r.dest_id = spec_free.pop_front();
      spec_map[d.dest_id] = r.dest_id;
    end
    else
      r.dest_id = phys_reg_t'(d.dest_id);
    e.new_reg = r.dest_id;
    r.rob_dest = rob_tail;
    rob_tail = rob_tail + 1'b1;
    r.sb_dest = store ? sb : last_sb;
    r.is_wfs = load && store_pending;
    if (store)
    begin
      last_sb = sb;
      store_pending = 1'b1;
    end
    rob_q.push_back(e);
  endtask

  task automatic model_retire();
    rob_entry_t e;
    e = rob_q.pop_front();
    rob_head = rob_head + 1'b1;
    if (e.w_v)
    begin
      spec_free.push_back(e.freed_reg);
      comm_free.push_back(e.freed_reg);
      comm_map[e.alloc_reg] = comm_free.pop_front();
    end
    // mispredicted branch restores committed state
    if (e.is_spec && e.mispredict)
    begin
      spec_map = comm_map;
      spec_free = comm_free;
      rob_q.delete();
      rob_head = '0;
      rob_tail = '0;
    end
  endtask

  // marks an entry done, returns how many entries retire
  task automatic model_complete(input rob_idx_t idx, input logic misp, output int n);
    rob_entry_t e;
    int pos;
    logic flush;
    pos = int'(rob_idx_t'(idx - rob_head));
    e = rob_q[pos];
    e.done = 1'b1;
    e.mispredict = misp;
    rob_q[pos] = e;
    n = 0;
    flush = 1'b0;
    while (!flush && rob_q.size() > 0 && rob_q[0].done)
    begin
      flush = rob_q[0].is_spec && rob_q[0].mispredict;
      model_retire();
      n++;
    end
  endtask

  task automatic present_instr(input step_t s);
    renamed_instr_t exp;
    logic exp_ready;
    logic store;
    store = (s.instr.func_unit == `RN_FU_MEM) && (s.instr.opcode == `RN_OP_STR);
    decoded_i = s.instr;
    decoded_v_i = 1'b1;
    sb_num_i = s.sb;
    if (s.kind == kind_stall)
    begin
      issue_ready_i = 1'b0;
      repeat (s.cycles)
      begin
        #1;
        check_ready("decode_ready_o", decode_ready_o, 1'b0);
        check_ready("sb_alloc_v_o", sb_alloc_v_o, 1'b0);
        check_ready("renamed_v_o", renamed_v_o, last_valid);
        if (last_valid)
          check_renamed(renamed_o, last_out);
        @(posedge clk_i);
        #1;
      end
      issue_ready_i = 1'b1;
    end
    #1;
    exp_ready = (spec_free.size() != 0) && (rob_q.size() < `RN_ROB_ENTRIES);
    check_ready("decode_ready_o", decode_ready_o, exp_ready);
    check_ready("sb_alloc_v_o", sb_alloc_v_o, exp_ready && store);
    @(posedge clk_i);
    #1;
    decoded_v_i = 1'b0;
    check_ready("renamed_v_o", renamed_v_o, exp_ready);
    if (exp_ready)
    begin
      predict_accept(s.instr, s.sb, exp);
      check_renamed(renamed_o, exp);
      last_out = exp;
    end
    last_valid = exp_ready;
  endtask

  task automatic send_completion(input step_t s);
    int n;
    int seen;
    complete_i.rob_idx = s.rob;
    complete_i.mispredict = s.mispredict;
    complete_v_i = 1'b1;
    model_complete(s.rob, s.mispredict, n);
    seen = 0;
    @(posedge clk_i);
    #1;
    complete_v_i = 1'b0;
    // one commit pulse per retiring entry
    while (seen < n)
    begin
      if (rename_unit_top_i.commit_v)
        seen++;
      @(posedge clk_i);
      #1;
    end
    last_valid = 1'b0;
  endtask

  task automatic clear_store(input step_t s);
    sb_clear_idx_i = s.sb;
    sb_clear_v_i = 1'b1;
    @(posedge clk_i);
    #1;
    sb_clear_v_i = 1'b0;
    if (store_pending && s.sb == last_sb)
      store_pending = 1'b0;
    last_valid = 1'b0;
  endtask

  initial
  begin
    wait (table_ready);
    repeat (steps.size() * 40 + 16) @(posedge clk_i);
    $display("timeout: the stimulus table did not finish in time");
    report_failure();
  end

  initial
  begin
    reset_i = 1'b1;
    decoded_i = '0;
    decoded_v_i = 1'b0;
    issue_ready_i = 1'b1;
    complete_v_i = 1'b0;
    complete_i = '0;
    sb_num_i = '0;
    sb_clear_v_i = 1'b0;
    sb_clear_idx_i = '0;
    build_table();
    table_ready = 1'b1;
    model_reset();
    repeat (16) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    @(posedge clk_i);
    #1;
    check_ready("decode_ready_o", decode_ready_o, 1'b1);
    check_ready("renamed_v_o", renamed_v_o, 1'b0);
    check_ready("commit_v", rename_unit_top_i.commit_v, 1'b0);
    foreach (steps[i])
    begin
      case (steps[i].kind)
        kind_issue,
        kind_stall: present_instr(steps[i]);
        kind_complete: send_completion(steps[i]);
        default: clear_store(steps[i]);
      endcase
    end
    if (rename_unit_top_i.u_rename_stage.u_rename_checks.failures != 0)
    begin
      $display("bound assertions failed %0d times",
               rename_unit_top_i.u_rename_stage.u_rename_checks.failures);
      report_failure();
    end
    else
    begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

// File: sim/rename_unit_assertions.sv
`timescale 1ns/1ps
`include "rename_consts.svh"

module rename_unit_assertions
  import rename_types_pkg::*;
(
  input logic                          clk_i,
  input logic                          reset_i,
  input logic                          decoded_v_i,
  input logic                          decode_ready_i,
  input logic                          issue_ready_i,
  input logic                          renamed_v_i,
  input renamed_instr_t                renamed_i,
  input logic [$clog2(`RN_PHYS_REGS):0] free_count_i
);

  int unsigned failures = 0;

  // output register holds under back-pressure
  hold_on_stall: assert property (@(posedge clk_i) disable iff (reset_i)
    renamed_v_i && !issue_ready_i |=> $stable(renamed_i))
    else
    begin
      failures++;
      $error("renamed_o changed while issue was stalled");
    end

  free_count_bound: assert property (@(posedge clk_i) disable iff (reset_i)
    free_count_i <= `RN_PHYS_REGS)
    else
    begin
      failures++;
      $error("free list count above the physical register count");
    end

  // a transfer always needs a free destination
  no_accept_when_empty: assert property (@(posedge clk_i) disable iff (reset_i)
    decoded_v_i && decode_ready_i |-> free_count_i != '0)
    else
    begin
      failures++;
      $error("instruction accepted with an empty free list");
    end

endmodule

bind rename_stage rename_unit_assertions u_rename_checks (
  .clk_i          (clk_i),
  .reset_i        (reset_i),
  .decoded_v_i    (decoded_v_i),
  .decode_ready_i (decode_ready_o),
  .issue_ready_i  (issue_ready_i),
  .renamed_v_i    (renamed_v_o),
  .renamed_i      (renamed_o),
  .free_count_i   (u_free_list.spec_count_q)
);

// File: logic/rename_unit_top.sv
`timescale 1ns/1ps

module rename_unit_top
  import rename_types_pkg::*, rob_types_pkg::*;
(
  input  logic           clk_i,
  input  logic           reset_i,
  input  decoded_instr_t decoded_i,
  input  logic           decoded_v_i,
  output logic           decode_ready_o,
  output renamed_instr_t renamed_o,
  output logic           renamed_v_o,
  input  logic           issue_ready_i,
  input  logic           complete_v_i,
  input  complete_rec_t  complete_i,
  input  sb_idx_t        sb_num_i,
  output logic           sb_alloc_v_o,
  input  logic           sb_clear_v_i,
  input  sb_idx_t        sb_clear_idx_i
);

  // rename to reorder buffer
  logic rob_ready;
  rob_idx_t rob_tail;
  logic rob_alloc_v;
  rob_entry_t rob_entry;

  // retirement back to rename
  logic commit_v;
  commit_rec_t commit_rec;
  logic commit_mispredict;

  rename_stage u_rename_stage (
    .clk_i,
    .reset_i,
    .decoded_i,
    .decoded_v_i,
    .decode_ready_o,
    .renamed_o,
    .renamed_v_o,
    .issue_ready_i,
    .rob_ready_i         (rob_ready),
    .rob_tail_i          (rob_tail),
    .rob_alloc_v_o       (rob_alloc_v),
    .rob_entry_o         (rob_entry),
    .commit_v_i          (commit_v),
    .commit_i            (commit_rec),
    .commit_mispredict_i (commit_mispredict),
    .sb_num_i,
    .sb_alloc_v_o,
    .sb_clear_v_i,
    .sb_clear_idx_i
  );

  reorder_buffer u_reorder_buffer (
    .clk_i,
    .reset_i,
    .alloc_v_i           (rob_alloc_v),
    .entry_i             (rob_entry),
    .ready_o             (rob_ready),
    .tail_o              (rob_tail),
    .complete_v_i,
    .complete_i,
    .commit_v_o          (commit_v),
    .commit_o            (commit_rec),
    .commit_mispredict_o (commit_mispredict)
  );

endmodule

// File: logic/reorder_buffer.sv
`timescale 1ns/1ps
`include "rename_consts.svh"

module reorder_buffer
  import rob_types_pkg::*;
(
  input  logic          clk_i,
  input  logic          reset_i,
  input  logic          alloc_v_i,
  input  rob_entry_t    entry_i,
  output logic          ready_o,
  output rob_idx_t      tail_o,
  input  logic          complete_v_i,
  input  complete_rec_t complete_i,
  output logic          commit_v_o,
  output commit_rec_t   commit_o,
  output logic          commit_mispredict_o
);

  rob_entry_t entries_q [`RN_ROB_ENTRIES];
  rob_entry_t head;
  rob_idx_t head_q;
  rob_idx_t tail_q;
  logic [`RN_ROB_IDX_W:0] count_q;
  logic head_fwd;
  logic head_done;
  logic head_mispredict;
  logic retire;
  logic flush;
  logic commit_v_q;
  logic commit_mispredict_q;
  commit_rec_t commit_q;

  assign head = entries_q[head_q];
  assign ready_o = (count_q != `RN_ROB_ENTRIES);
  assign tail_o = tail_q;

  // completion of the head this cycle lets it retire on the same edge
  assign head_fwd = complete_v_i && (complete_i.rob_idx == head_q);
  assign head_done = head.done | head_fwd;
  assign head_mispredict = head.is_spec &
                           (head_fwd ? complete_i.mispredict : head.mispredict);

  // mispredict commit on the output empties the buffer
  assign flush = commit_v_q & commit_mispredict_q;
  assign retire = (count_q != '0) && head_done && !flush;

  always_ff @(posedge clk_i)
  begin
    if (reset_i || flush)
    begin
      head_q <= '0;
      tail_q <= '0;
      count_q <= '0;
      commit_v_q <= 1'b0;
      commit_mispredict_q <= 1'b0;
    end
    else
    begin
      if (alloc_v_i)
        tail_q <= tail_q + 1'b1;
      if (retire)
        head_q <= head_q + 1'b1;
      case ({alloc_v_i, retire})
        2'b10: count_q <= count_q + 1'b1;
        2'b01: count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      commit_v_q <= retire;
      commit_mispredict_q <= retire & head_mispredict;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (retire)
    begin
      commit_q.w_v <= head.w_v;
      commit_q.alloc_reg <= head.alloc_reg;
      commit_q.freed_reg <= head.freed_reg;
    end
    if (alloc_v_i)
      entries_q[tail_q] <= entry_i;
    if (complete_v_i)
    begin
      entries_q[complete_i.rob_idx].done <= 1'b1;
      entries_q[complete_i.rob_idx].mispredict <= complete_i.mispredict;
    end
  end

  assign commit_v_o = commit_v_q;
  assign commit_o = commit_q;
  assign commit_mispredict_o = commit_mispredict_q;

endmodule

// File: logic/rename_stage.sv
`timescale 1ns/1ps
`include "rename_consts.svh"

module rename_stage
  import rename_types_pkg::*, rob_types_pkg::*;
(
  input  logic           clk_i,
  input  logic           reset_i,
  input  decoded_instr_t decoded_i,
  input  logic           decoded_v_i,
  output logic           decode_ready_o,
  output renamed_instr_t renamed_o,
  output logic           renamed_v_o,
  input  logic           issue_ready_i,
  input  logic           rob_ready_i,
  input  rob_idx_t       rob_tail_i,
  output logic           rob_alloc_v_o,
  output rob_entry_t     rob_entry_o,
  input  logic           commit_v_i,
  input  commit_rec_t    commit_i,
  input  logic           commit_mispredict_i,
  input  sb_idx_t        sb_num_i,
  output logic           sb_alloc_v_o,
  input  logic           sb_clear_v_i,
  input  sb_idx_t        sb_clear_idx_i
);

  logic rollback;
  logic accept;
  logic alloc_dest;
  logic retire_writer;
  logic fl_empty;
  logic is_load;
  logic is_store;
  logic is_branch;
  phys_reg_t src1_phys;
  phys_reg_t src2_phys;
  phys_reg_t old_dest_phys;
  phys_reg_t new_dest_phys;
  phys_reg_t commit_head;
  renamed_instr_t renamed_n;
  renamed_instr_t renamed_q;
  logic renamed_v_q;
  sb_idx_t sb_num_q;
  logic store_pending_q;
  logic store_pending_now;

  assign rollback = commit_v_i & commit_mispredict_i;
  assign retire_writer = commit_v_i & commit_i.w_v;

  assign decode_ready_o = !fl_empty && !rollback && issue_ready_i && rob_ready_i;
  assign accept = decoded_v_i & decode_ready_o;
  assign alloc_dest = accept & decoded_i.w_v;
  assign rob_alloc_v_o = accept;
  assign sb_alloc_v_o = accept & is_store;

  assign is_load = (decoded_i.func_unit == `RN_FU_MEM) && (decoded_i.opcode == `RN_OP_LDR);
  assign is_store = (decoded_i.func_unit == `RN_FU_MEM) && (decoded_i.opcode == `RN_OP_STR);
  assign is_branch = (decoded_i.func_unit == `RN_FU_BRANCH) &&
                     (decoded_i.opcode == `RN_OP_BX || decoded_i.opcode == `RN_OP_BCC);

  // older store still outstanding, counting a clear this cycle
  assign store_pending_now = store_pending_q &&
                             !(sb_clear_v_i && sb_clear_idx_i == sb_num_q);

  rename_map_table u_map_table (
    .clk_i,
    .reset_i,
    .rd1_idx_i    (decoded_i.source_1),
    .rd2_idx_i    (arch_reg_t'(decoded_i.source2_imm)),
    .rdd_idx_i    (decoded_i.dest_id),
    .rd1_o        (src1_phys),
    .rd2_o        (src2_phys),
    .rdd_o        (old_dest_phys),
    .spec_we_i    (alloc_dest),
    .spec_idx_i   (decoded_i.dest_id),
    .spec_val_i   (new_dest_phys),
    .commit_we_i  (retire_writer),
    .commit_idx_i (commit_i.alloc_reg),
    .commit_val_i (commit_head),
    .rollback_i   (rollback)
  );

  rename_free_list u_free_list (
    .clk_i,
    .reset_i,
    .alloc_i       (alloc_dest),
    .alloc_reg_o   (new_dest_phys),
    .free_i        (retire_writer),
    .free_reg_i    (commit_i.freed_reg),
    .commit_i      (retire_writer),
    .commit_head_o (commit_head),
    .rollback_i    (rollback),
    .empty_o       (fl_empty)
  );

  always_comb
  begin
    renamed_n.pc = decoded_i.pc;
    renamed_n.opcode = decoded_i.opcode;
    renamed_n.func_unit = decoded_i.func_unit;
    renamed_n.imm = decoded_i.imm;
    renamed_n.w_v = decoded_i.w_v;
    renamed_n.source_1 = src1_phys;
    // immediates pass through untouched
    renamed_n.source2_imm = decoded_i.imm ? decoded_i.source2_imm : word_t'(src2_phys);
    renamed_n.dest_id = decoded_i.w_v ? new_dest_phys : phys_reg_t'(decoded_i.dest_id);
    renamed_n.rob_dest = rob_tail_i;
    renamed_n.sb_dest = is_store ? sb_num_i : sb_num_q;
    renamed_n.is_wfs = is_load & store_pending_now;
  end

  always_comb
  begin
    rob_entry_o.pc = decoded_i.pc;
    rob_entry_o.w_v = decoded_i.w_v;
    rob_entry_o.alloc_reg = decoded_i.dest_id;
    rob_entry_o.new_reg = new_dest_phys;
    rob_entry_o.freed_reg = old_dest_phys;
    rob_entry_o.is_spec = is_branch;
    rob_entry_o.is_store = is_store;
    rob_entry_o.done = 1'b0;
    rob_entry_o.mispredict = 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      renamed_v_q <= 1'b0;
      sb_num_q <= '0;
      store_pending_q <= 1'b0;
    end
    else
    begin
      // output stage holds while issue stalls
      if (issue_ready_i)
        renamed_v_q <= accept;
      if (sb_alloc_v_o)
      begin
        sb_num_q <= sb_num_i;
        store_pending_q <= 1'b1;
      end
      else
        store_pending_q <= store_pending_now;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (issue_ready_i)
      renamed_q <= renamed_n;
  end

  assign renamed_o = renamed_q;
  assign renamed_v_o = renamed_v_q;

endmodule

// File: logic/rename_free_list.sv
`timescale 1ns/1ps
`include "rename_consts.svh"

module rename_free_list
  import rename_types_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      alloc_i,
  output phys_reg_t alloc_reg_o,
  input  logic      free_i,
  input  phys_reg_t free_reg_i,
  input  logic      commit_i,
  output phys_reg_t commit_head_o,
  input  logic      rollback_i,
  output logic      empty_o
);

  typedef logic [$clog2(`RN_PHYS_REGS)-1:0] fl_ptr_t;
  typedef logic [$clog2(`RN_PHYS_REGS):0] fl_count_t;

  phys_reg_t [`RN_PHYS_REGS-1:0] spec_q;
  phys_reg_t [`RN_PHYS_REGS-1:0] spec_n;
  phys_reg_t [`RN_PHYS_REGS-1:0] comm_q;
  phys_reg_t [`RN_PHYS_REGS-1:0] comm_n;
  fl_ptr_t spec_rd_q;
  fl_ptr_t spec_rd_n;
  fl_ptr_t spec_wr_q;
  fl_ptr_t spec_wr_n;
  fl_ptr_t comm_rd_q;
  fl_ptr_t comm_rd_n;
  fl_ptr_t comm_wr_q;
  fl_ptr_t comm_wr_n;
  fl_count_t spec_count_q;
  fl_count_t spec_count_n;

  assign alloc_reg_o = spec_q[spec_rd_q];
  assign commit_head_o = comm_q[comm_rd_q];
  assign empty_o = (spec_count_q == '0);

  // committed list pops in allocation order
  always_comb
  begin
    comm_n = comm_q;
    comm_rd_n = comm_rd_q;
    comm_wr_n = comm_wr_q;
    if (free_i)
    begin
      comm_n[comm_wr_q] = free_reg_i;
      comm_wr_n = comm_wr_q + 1'b1;
    end
    if (commit_i)
      comm_rd_n = comm_rd_q + 1'b1;
  end

  always_comb
  begin
    spec_n = spec_q;
    spec_rd_n = spec_rd_q;
    spec_wr_n = spec_wr_q;
    spec_count_n = spec_count_q;
    if (alloc_i)
      spec_rd_n = spec_rd_q + 1'b1;
    if (free_i)
    begin
      spec_n[spec_wr_q] = free_reg_i;
      spec_wr_n = spec_wr_q + 1'b1;
    end
    case ({alloc_i, free_i})
      2'b10: spec_count_n = spec_count_q - 1'b1;
      2'b01: spec_count_n = spec_count_q + 1'b1;
      default: spec_count_n = spec_count_q;
    endcase
    // committed side always holds phys minus arch entries
    if (rollback_i)
    begin
      spec_n = comm_n;
      spec_rd_n = comm_rd_n;
      spec_wr_n = comm_wr_n;
      spec_count_n = fl_count_t'(`RN_PHYS_REGS - `RN_ARCH_REGS);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      // registers above the arch range start out free
      for (int i = 0; i < `RN_PHYS_REGS; i++)
      begin
        spec_q[i] <= phys_reg_t'(i + `RN_ARCH_REGS);
        comm_q[i] <= phys_reg_t'(i + `RN_ARCH_REGS);
      end
      spec_rd_q <= '0;
      comm_rd_q <= '0;
      spec_wr_q <= fl_ptr_t'(`RN_PHYS_REGS - `RN_ARCH_REGS);
      comm_wr_q <= fl_ptr_t'(`RN_PHYS_REGS - `RN_ARCH_REGS);
      spec_count_q <= fl_count_t'(`RN_PHYS_REGS - `RN_ARCH_REGS);
    end
    else
    begin
      spec_q <= spec_n;
      comm_q <= comm_n;
      spec_rd_q <= spec_rd_n;
      comm_rd_q <= comm_rd_n;
      spec_wr_q <= spec_wr_n;
      comm_wr_q <= comm_wr_n;
      spec_count_q <= spec_count_n;
    end
  end

endmodule

// File: logic/rename_map_table.sv
`timescale 1ns/1ps
`include "rename_consts.svh"

module rename_map_table
  import rename_types_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  arch_reg_t rd1_idx_i,
  input  arch_reg_t rd2_idx_i,
  input  arch_reg_t rdd_idx_i,
  output phys_reg_t rd1_o,
  output phys_reg_t rd2_o,
  output phys_reg_t rdd_o,
  input  logic      spec_we_i,
  input  arch_reg_t spec_idx_i,
  input  phys_reg_t spec_val_i,
  input  logic      commit_we_i,
  input  arch_reg_t commit_idx_i,
  input  phys_reg_t commit_val_i,
  input  logic      rollback_i
);

  phys_reg_t [`RN_ARCH_REGS-1:0] spec_q;
  phys_reg_t [`RN_ARCH_REGS-1:0] spec_n;
  phys_reg_t [`RN_ARCH_REGS-1:0] comm_q;
  phys_reg_t [`RN_ARCH_REGS-1:0] comm_n;

  // lookups see the speculative copy only
  assign rd1_o = spec_q[rd1_idx_i];
  assign rd2_o = spec_q[rd2_idx_i];
  assign rdd_o = spec_q[rdd_idx_i];

  always_comb
  begin
    comm_n = comm_q;
    if (commit_we_i)
      comm_n[commit_idx_i] = commit_val_i;

    spec_n = spec_q;
    if (spec_we_i)
      spec_n[spec_idx_i] = spec_val_i;
    // restore includes this cycle's commit write
    if (rollback_i)
      spec_n = comm_n;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      // identity mapping
      for (int r = 0; r < `RN_ARCH_REGS; r++)
      begin
        spec_q[r] <= phys_reg_t'(r);
        comm_q[r] <= phys_reg_t'(r);
      end
    end
    else
    begin
      spec_q <= spec_n;
      comm_q <= comm_n;
    end
  end

endmodule

// File: logic/rob_types_pkg.sv
`include "rename_consts.svh"

package rob_types_pkg;

  import rename_types_pkg::*;

  typedef logic [`RN_ROB_IDX_W-1:0] rob_idx_t;
  typedef logic [`RN_SB_IDX_W-1:0] sb_idx_t;

  typedef struct packed {
    word_t     pc;
    logic      w_v;
    arch_reg_t alloc_reg;
    phys_reg_t new_reg;
    // previous mapping, released at retirement
    phys_reg_t freed_reg;
    logic      is_spec;
    logic      is_store;
    logic      done;
    logic      mispredict;
  } rob_entry_t;

  // what retirement hands back to rename
  typedef struct packed {
    logic      w_v;
    arch_reg_t alloc_reg;
    phys_reg_t freed_reg;
  } commit_rec_t;

  typedef struct packed {
    rob_idx_t rob_idx;
    logic     mispredict;
  } complete_rec_t;

endpackage

// File: logic/rename_types_pkg.sv
`include "rename_consts.svh"

package rename_types_pkg;

  // register indices
  typedef logic [$clog2(`RN_ARCH_REGS)-1:0] arch_reg_t;
  typedef logic [$clog2(`RN_PHYS_REGS)-1:0] phys_reg_t;

  typedef logic [`RN_WORD-1:0] word_t;
  typedef logic [`RN_OP_W-1:0] opcode_t;
  typedef logic [`RN_FU_W-1:0] func_unit_t;

  // instruction as it leaves decode
  typedef struct packed {
    word_t      pc;
    opcode_t    opcode;
    func_unit_t func_unit;
    logic       imm;
    logic       w_v;
    arch_reg_t  source_1;
    // immediate, or source 2 in the low bits
    word_t      source2_imm;
    arch_reg_t  dest_id;
  } decoded_instr_t;

  // instruction as it goes to issue
  typedef struct packed {
    word_t                   pc;
    opcode_t                 opcode;
    func_unit_t              func_unit;
    logic                    imm;
    logic                    w_v;
    phys_reg_t               source_1;
    word_t                   source2_imm;
    phys_reg_t               dest_id;
    logic [`RN_ROB_IDX_W-1:0] rob_dest;
    logic [`RN_SB_IDX_W-1:0]  sb_dest;
    // load must wait for an older store
    logic                    is_wfs;
  } renamed_instr_t;

endpackage

// File: logic/rename_consts.svh
`ifndef RENAME_CONSTS_SVH
`define RENAME_CONSTS_SVH

// register file sizes
`define RN_ARCH_REGS 16
`define RN_PHYS_REGS 32

// queue depths and the index widths derived from them
`define RN_ROB_ENTRIES 8
`define RN_SB_ENTRIES 4
`define RN_ROB_IDX_W ($clog2(`RN_ROB_ENTRIES))
`define RN_SB_IDX_W ($clog2(`RN_SB_ENTRIES))

`define RN_WORD 32

// opcode field
`define RN_OP_W 4
`define RN_OP_LDR 4'h1
`define RN_OP_STR 4'h2
`define RN_OP_BX 4'h3
`define RN_OP_BCC 4'h4

// functional unit field
`define RN_FU_W 2
`define RN_FU_ALU 2'd0
`define RN_FU_MEM 2'd1
`define RN_FU_BRANCH 2'd2

`endif
